// ==== llcopy_pkg.sv ====
package llcopy_pkg;

   typedef logic [31:0] word_t;

   // invalid trailing bytes, counted from the low end
   typedef logic [1:0] rem_t;

   typedef logic [15:0] byte_cnt_t;

   typedef enum logic [2:0] {
      OP_NONE   = 3'd0,
      OP_COPY   = 3'd1,
      OP_DECOMP = 3'd2,
      OP_COMP   = 3'd4
   } opcode_e;

   typedef struct packed {
      word_t data;
      rem_t  rem;
      logic  sof;
      logic  eof;
      // last payload beat, output side only
      logic  eop;
   } ll_beat_t;

   typedef struct packed {
      opcode_e     opcode;
      logic [31:0] src_len;
      logic [9:0]  task_index;
   } desc_t;

   localparam int HDR_WORDS      = 8;
   localparam int HDR_OPCODE_IDX = 4;
   localparam int HDR_LEN_IDX    = 5;
   localparam int HDR_TASK_IDX   = 6;

   function automatic word_t mask_tail(input word_t data, input rem_t rem);
      word_t masked;
      case (rem)
         2'd0: begin
            masked = data;
         end
         2'd1: begin
            masked = {data[31:8], 8'h00};
         end
         2'd2: begin
            masked = {data[31:16], 16'h0000};
         end
         default: begin
            masked = {data[31:24], 24'h000000};
         end
      endcase
      return masked;
   endfunction

endpackage

// ==== ingress_fsm.sv ====
module ingress_fsm (
   input  logic                 clk,
   input  logic                 rst_n,
   input  llcopy_pkg::ll_beat_t in_beat_i,
   input  logic                 in_valid_i,
   output logic                 in_ready_o,
   output logic                 hdr_we_o,
   output logic [2:0]           hdr_idx_o,
   output llcopy_pkg::ll_beat_t pay_beat_o,
   output logic                 pay_valid_o,
   input  logic                 pay_ready_i,
   input  logic                 cpl_done_i
);

   typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD, WAIT_CPL} state_e;

   state_e     state_q;
   state_e     state_d;
   logic [2:0] hdr_cnt_q;
   logic       armed_q;

   assign pay_beat_o = in_beat_i;
   // counter sits at zero in IDLE and wraps after word 7
   assign hdr_idx_o  = hdr_cnt_q;

   always_comb begin
      in_ready_o  = 1'b0;
      hdr_we_o    = 1'b0;
      pay_valid_o = 1'b0;
      state_d     = state_q;
      case (state_q)
         IDLE: begin
            // stray beats without sof are taken and dropped
            in_ready_o = armed_q;
            if (in_valid_i && armed_q && in_beat_i.sof) begin
               hdr_we_o = 1'b1;
               state_d  = HEADER;
            end
         end
         HEADER: begin
            in_ready_o = 1'b1;
            hdr_we_o   = in_valid_i;
            if (in_valid_i && (hdr_cnt_q == 3'(llcopy_pkg::HDR_WORDS - 1))) begin
               state_d = PAYLOAD;
            end
         end
         PAYLOAD: begin
            in_ready_o  = pay_ready_i;
            pay_valid_o = in_valid_i;
            if (in_valid_i && pay_ready_i && in_beat_i.eof) begin
               state_d = WAIT_CPL;
            end
         end
         default: begin
            if (cpl_done_i) begin
               state_d = IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= IDLE;
         hdr_cnt_q <= '0;
         armed_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         armed_q <= 1'b1;
         if (hdr_we_o) begin
            hdr_cnt_q <= hdr_cnt_q + 3'd1;
         end
      end
   end

endmodule

// ==== desc_capture.sv ====
module desc_capture (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              hdr_we_i,
   input  logic [2:0]        hdr_idx_i,
   input  llcopy_pkg::word_t hdr_data_i,
   output llcopy_pkg::desc_t desc_o
);

   llcopy_pkg::desc_t desc_q;

   assign desc_o = desc_q;

   // other header words carry nothing we need
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         desc_q <= '0;
      end else if (hdr_we_i) begin
         case (hdr_idx_i)
            3'(llcopy_pkg::HDR_OPCODE_IDX): begin
               desc_q.opcode <= llcopy_pkg::opcode_e'(hdr_data_i[31:29]);
            end
            3'(llcopy_pkg::HDR_LEN_IDX): begin
               desc_q.src_len <= hdr_data_i;
            end
            3'(llcopy_pkg::HDR_TASK_IDX): begin
               desc_q.task_index <= hdr_data_i[9:0];
            end
            default: begin
               desc_q <= desc_q;
            end
         endcase
      end
   end

endmodule

// ==== payload_fifo.sv ====
module payload_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  llcopy_pkg::ll_beat_t  pay_beat_i,
   input  logic                  pay_valid_i,
   output logic                  pay_ready_o,
   input  llcopy_pkg::opcode_e   opcode_i,
   output llcopy_pkg::word_t     fifo_data_o,
   output llcopy_pkg::rem_t      fifo_rem_o,
   output logic                  fifo_last_o,
   output logic                  fifo_valid_o,
   input  logic                  fifo_ready_i,
   output logic                  pay_done_o,
   output llcopy_pkg::byte_cnt_t byte_cnt_o
);

   localparam int AW = $clog2(FIFO_DEPTH);

   typedef struct packed {
      llcopy_pkg::word_t data;
      llcopy_pkg::rem_t  rem;
      logic              last;
   } entry_t;

   entry_t                mem [FIFO_DEPTH];
   entry_t                wr_entry;
   entry_t                rd_entry;
   logic [AW:0]           wr_ptr_q;
   logic [AW:0]           rd_ptr_q;
   logic                  full;
   logic                  is_copy;
   logic                  pay_xfer;
   logic                  wr_en;
   logic                  rd_en;
   logic                  first_q;
   logic                  pay_done_q;
   logic [2:0]            beat_bytes;
   llcopy_pkg::byte_cnt_t byte_cnt_q;
   llcopy_pkg::byte_cnt_t cnt_base;

   assign is_copy = (opcode_i == llcopy_pkg::OP_COPY);
   assign full    = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                    (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

   // dropped frames drain at full rate
   assign pay_ready_o = !full || !is_copy;
   assign pay_xfer    = pay_valid_i && pay_ready_o;
   assign wr_en       = pay_xfer && is_copy;

   assign fifo_valid_o = (wr_ptr_q != rd_ptr_q);
   assign rd_en        = fifo_valid_o && fifo_ready_i;
   assign rd_entry     = mem[rd_ptr_q[AW-1:0]];
   assign fifo_data_o  = rd_entry.data;
   assign fifo_rem_o   = rd_entry.rem;
   assign fifo_last_o  = rd_entry.last;

   assign pay_done_o = pay_done_q;
   assign byte_cnt_o = byte_cnt_q;
   assign cnt_base   = first_q ? '0 : byte_cnt_q;

   always_comb begin
      wr_entry.data = pay_beat_i.data;
      wr_entry.rem  = '0;
      wr_entry.last = pay_beat_i.eof;
      beat_bytes    = 3'd4;
      if (pay_beat_i.eof) begin
         wr_entry.data = llcopy_pkg::mask_tail(pay_beat_i.data, pay_beat_i.rem);
         wr_entry.rem  = pay_beat_i.rem;
         beat_bytes    = 3'd4 - {1'b0, pay_beat_i.rem};
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr_q[AW-1:0]] <= wr_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         first_q    <= 1'b1;
         byte_cnt_q <= '0;
         pay_done_q <= 1'b0;
      end else begin
         pay_done_q <= pay_xfer && pay_beat_i.eof;
         if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // first beat of a frame restarts the count
         if (pay_xfer) begin
            first_q    <= pay_beat_i.eof;
            byte_cnt_q <= is_copy ? cnt_base + 16'(beat_bytes) : '0;
         end
      end
   end

endmodule

// ==== cpl_framer.sv ====
module cpl_framer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  llcopy_pkg::word_t     fifo_data_i,
   input  llcopy_pkg::rem_t      fifo_rem_i,
   input  logic                  fifo_last_i,
   input  logic                  fifo_valid_i,
   output logic                  fifo_ready_o,
   input  logic                  pay_done_i,
   input  llcopy_pkg::byte_cnt_t byte_cnt_i,
   input  llcopy_pkg::desc_t     desc_i,
   output llcopy_pkg::ll_beat_t  out_beat_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i,
   output logic                  cpl_done_o
);

   typedef enum logic [1:0] {IDLE, PAYLOAD, WAIT_DONE, HEADER} state_e;

   state_e            state_q;
   logic [2:0]        hdr_cnt_q;
   logic              done_q;
   logic              first_q;
   logic              status;
   logic              last_hdr;
   llcopy_pkg::word_t hdr_word;

   assign status   = (desc_i.opcode == llcopy_pkg::OP_COPY) &&
                     (byte_cnt_i == desc_i.src_len[15:0]);
   assign last_hdr = (hdr_cnt_q == 3'(llcopy_pkg::HDR_WORDS - 1));

   // completion header layout
   always_comb begin
      case (hdr_cnt_q)
         3'(llcopy_pkg::HDR_OPCODE_IDX): begin
            hdr_word = {desc_i.opcode, status, 28'h0};
         end
         3'(llcopy_pkg::HDR_LEN_IDX): begin
            hdr_word = {16'h0, byte_cnt_i};
         end
         3'(llcopy_pkg::HDR_TASK_IDX): begin
            hdr_word = {22'h0, desc_i.task_index};
         end
         default: begin
            hdr_word = '0;
         end
      endcase
   end

   always_comb begin
      out_beat_o   = '0;
      out_valid_o  = 1'b0;
      fifo_ready_o = 1'b0;
      cpl_done_o   = 1'b0;
      case (state_q)
         PAYLOAD: begin
            out_beat_o.data = fifo_data_i;
            out_beat_o.rem  = fifo_rem_i;
            out_beat_o.sof  = first_q;
            out_beat_o.eop  = fifo_last_i;
            out_valid_o     = fifo_valid_i;
            fifo_ready_o    = out_ready_i;
         end
         HEADER: begin
            out_beat_o.data = hdr_word;
            // no payload went out, so the header opens the frame
            out_beat_o.sof  = first_q && (hdr_cnt_q == 3'd0);
            out_beat_o.eof  = last_hdr;
            out_valid_o     = 1'b1;
            cpl_done_o      = out_ready_i && last_hdr;
         end
         default: begin
            out_valid_o = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= IDLE;
         hdr_cnt_q <= '0;
         done_q    <= 1'b0;
         first_q   <= 1'b1;
      end else begin
         if (pay_done_i) begin
            done_q <= 1'b1;
         end
         case (state_q)
            IDLE: begin
               if (fifo_valid_i) begin
                  state_q <= PAYLOAD;
               end else if (done_q) begin
                  state_q <= HEADER;
               end
            end
            PAYLOAD: begin
               if (fifo_valid_i && out_ready_i) begin
                  first_q <= 1'b0;
                  if (fifo_last_i) begin
                     state_q <= done_q ? HEADER : WAIT_DONE;
                  end
               end
            end
            WAIT_DONE: begin
               if (done_q) begin
                  state_q <= HEADER;
               end
            end
            default: begin
               if (out_ready_i) begin
                  hdr_cnt_q <= hdr_cnt_q + 3'd1;
                  if (last_hdr) begin
                     state_q <= IDLE;
                     done_q  <= 1'b0;
                     first_q <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

endmodule

// ==== llcopy_unit.sv ====
module llcopy_unit #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  llcopy_pkg::ll_beat_t in_beat_i,
   input  logic                 in_valid_i,
   output logic                 in_ready_o,
   output llcopy_pkg::ll_beat_t out_beat_o,
   output logic                 out_valid_o,
   input  logic                 out_ready_i
);

   logic                  hdr_we;
   logic [2:0]            hdr_idx;
   llcopy_pkg::ll_beat_t  pay_beat;
   logic                  pay_valid;
   logic                  pay_ready;
   llcopy_pkg::word_t     fifo_data;
   llcopy_pkg::rem_t      fifo_rem;
   logic                  fifo_last;
   logic                  fifo_valid;
   logic                  fifo_ready;
   logic                  pay_done;
   llcopy_pkg::byte_cnt_t byte_cnt;
   llcopy_pkg::desc_t     desc;
   logic                  cpl_done;

   ingress_fsm u_ingress (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat_i   (in_beat_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .hdr_we_o    (hdr_we),
      .hdr_idx_o   (hdr_idx),
      .pay_beat_o  (pay_beat),
      .pay_valid_o (pay_valid),
      .pay_ready_i (pay_ready),
      .cpl_done_i  (cpl_done)
   );

   desc_capture u_desc (
      .clk        (clk),
      .rst_n      (rst_n),
      .hdr_we_i   (hdr_we),
      .hdr_idx_i  (hdr_idx),
      .hdr_data_i (in_beat_i.data),
      .desc_o     (desc)
   );

   payload_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk          (clk),
      .rst_n        (rst_n),
      .pay_beat_i   (pay_beat),
      .pay_valid_i  (pay_valid),
      .pay_ready_o  (pay_ready),
      .opcode_i     (desc.opcode),
      .fifo_data_o  (fifo_data),
      .fifo_rem_o   (fifo_rem),
      .fifo_last_o  (fifo_last),
      .fifo_valid_o (fifo_valid),
      .fifo_ready_i (fifo_ready),
      .pay_done_o   (pay_done),
      .byte_cnt_o   (byte_cnt)
   );

   cpl_framer u_framer (
      .clk          (clk),
      .rst_n        (rst_n),
      .fifo_data_i  (fifo_data),
      .fifo_rem_i   (fifo_rem),
      .fifo_last_i  (fifo_last),
      .fifo_valid_i (fifo_valid),
      .fifo_ready_o (fifo_ready),
      .pay_done_i   (pay_done),
      .byte_cnt_i   (byte_cnt),
      .desc_i       (desc),
      .out_beat_o   (out_beat_o),
      .out_valid_o  (out_valid_o),
      .out_ready_i  (out_ready_i),
      .cpl_done_o   (cpl_done)
   );

endmodule

// ==== llcopy_unit_sva.sv ====
module llcopy_unit_sva (
   input logic                 clk,
   input logic                 rst_n,
   input llcopy_pkg::ll_beat_t in_beat_i,
   input logic                 in_valid_i,
   input logic                 in_ready_o,
   input llcopy_pkg::ll_beat_t out_beat_o,
   input logic                 out_valid_o,
   input logic                 out_ready_i
);
   timeunit 1ns;
   timeprecision 100ps;

   logic        busy_q;
   int unsigned err_cnt = 0;

   // set between an input eof and the matching output eof
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
      end else if (in_valid_i && in_ready_o && in_beat_i.eof) begin
         busy_q <= 1'b1;
      end else if (out_valid_o && out_ready_i && out_beat_o.eof) begin
         busy_q <= 1'b0;
      end
   end

   hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o))
   else begin
      err_cnt = err_cnt + 1;
      $error("output beat changed or dropped while stalled");
   end

   input_blocked: assert property (@(posedge clk) disable iff (!rst_n)
      busy_q |-> !in_ready_o)
   else begin
      err_cnt = err_cnt + 1;
      $error("input accepted before the completion frame finished");
   end

   quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid_o)
   else begin
      err_cnt = err_cnt + 1;
      $error("output valid during reset");
   end

endmodule

// ==== tb_llcopy_unit.sv ====
module tb_llcopy_unit;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_FRAMES   = 40;
   localparam int MAX_WORDS  = 12;
   localparam int MAX_CYCLES = N_FRAMES * (4 * llcopy_pkg::HDR_WORDS + 2 * MAX_WORDS) * 4;

   logic                 clk;
   logic                 rst_n;
   llcopy_pkg::ll_beat_t in_beat_i;
   logic                 in_valid_i;
   logic                 in_ready_o;
   llcopy_pkg::ll_beat_t out_beat_o;
   logic                 out_valid_o;
   logic                 out_ready_i;

   logic [15:0]          lfsr_q;
   llcopy_pkg::ll_beat_t in_q[$];
   llcopy_pkg::ll_beat_t exp_q[$];
   int                   frames_done = 0;
   int                   beat_no = 0;

   llcopy_unit #(
      .FIFO_DEPTH (4)
   ) llcopy_unit_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat_i   (in_beat_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_beat_o  (out_beat_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   bind llcopy_unit llcopy_unit_sva sva_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat_i   (in_beat_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_beat_o  (out_beat_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // galois form, taps 16,14,13,11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   function automatic llcopy_pkg::word_t zero_tail(input llcopy_pkg::word_t data,
                                                   input llcopy_pkg::rem_t rem);
      return data & (32'hFFFF_FFFF << (8 * int'(rem)));
   endfunction

   task automatic check_word(input string name, input llcopy_pkg::word_t exp_w,
                             input llcopy_pkg::word_t act_w);
      if (act_w !== exp_w) begin
         $display("CHECK FAILED %s: expected %08h actual %08h", name, exp_w, act_w);
         $display("Simulation FAILED");
         $fatal(1, "data word mismatch");
      end
   endtask

   task automatic check_beat(input string name, input llcopy_pkg::ll_beat_t exp_b,
                             input llcopy_pkg::ll_beat_t act_b);
      string exp_s;
      string act_s;
      if (act_b !== exp_b) begin
         exp_s = $sformatf("data=%08h rem=%0d sof=%0b eof=%0b eop=%0b",
                           exp_b.data, exp_b.rem, exp_b.sof, exp_b.eof, exp_b.eop);
         act_s = $sformatf("data=%08h rem=%0d sof=%0b eof=%0b eop=%0b",
                           act_b.data, act_b.rem, act_b.sof, act_b.eof, act_b.eop);
         $display("CHECK FAILED %s: expected %s actual %s", name, exp_s, act_s);
         $display("Simulation FAILED");
         $fatal(1, "beat mismatch");
      end
   endtask

   // input frame plus the completion frame it should produce
   task automatic build_frame();
      logic [2:0]            op;
      int                    n_words;
      llcopy_pkg::rem_t      rem;
      logic                  len_ok;
      logic                  is_copy;
      logic                  last;
      logic [9:0]            task_idx;
      llcopy_pkg::byte_cnt_t bytes;
      llcopy_pkg::byte_cnt_t out_bytes;
      llcopy_pkg::word_t     data;
      llcopy_pkg::ll_beat_t  beat;
      op        = take_bits(1) ? 3'(llcopy_pkg::OP_COPY) : 3'(take_bits(3));
      n_words   = 1 + int'(take_bits(4)) % MAX_WORDS;
      rem       = 2'(take_bits(2));
      len_ok    = (take_bits(2) != 32'd0);
      task_idx  = 10'(take_bits(10));
      is_copy   = (op == 3'(llcopy_pkg::OP_COPY));
      bytes     = 16'(4 * n_words) - 16'(rem);
      out_bytes = is_copy ? bytes : 16'd0;
      for (int i = 0; i < llcopy_pkg::HDR_WORDS; i++) begin
         beat      = '0;
         beat.sof  = (i == 0);
         beat.data = take_bits(32);
         if (i == llcopy_pkg::HDR_OPCODE_IDX) begin
            beat.data[31:29] = op;
         end
         if (i == llcopy_pkg::HDR_LEN_IDX) begin
            // a wrong length is off by one byte
            beat.data = {16'h0, len_ok ? bytes : bytes + 16'd1};
         end
         if (i == llcopy_pkg::HDR_TASK_IDX) begin
            beat.data[9:0] = task_idx;
         end
         in_q.push_back(beat);
      end
      for (int i = 0; i < n_words; i++) begin
         last      = (i == n_words - 1);
         data      = take_bits(32);
         beat      = '0;
         beat.data = data;
         beat.eof  = last;
         beat.rem  = last ? rem : 2'd0;
         in_q.push_back(beat);
         if (is_copy) begin
            beat.data = last ? zero_tail(data, rem) : data;
            beat.sof  = (i == 0);
            beat.eof  = 1'b0;
            beat.eop  = last;
            exp_q.push_back(beat);
         end
      end
      for (int i = 0; i < llcopy_pkg::HDR_WORDS; i++) begin
         beat     = '0;
         beat.sof = !is_copy && (i == 0);
         beat.eof = (i == llcopy_pkg::HDR_WORDS - 1);
         if (i == llcopy_pkg::HDR_OPCODE_IDX) begin
            beat.data = {op, is_copy && len_ok, 28'h0};
         end else if (i == llcopy_pkg::HDR_LEN_IDX) begin
            beat.data = {16'h0, out_bytes};
         end else if (i == llcopy_pkg::HDR_TASK_IDX) begin
            beat.data = {22'h0, task_idx};
         end
         exp_q.push_back(beat);
      end
   endtask

   task automatic send_beat(input llcopy_pkg::ll_beat_t beat);
      logic took;
      in_beat_i  = beat;
      in_valid_i = 1'b1;
      took       = 1'b0;
      while (!took) begin
         @(negedge clk);
         took = in_ready_o;
         @(posedge clk);
         #1;
      end
      in_valid_i = 1'b0;
   endtask

   initial begin
      in_beat_i   = '0;
      in_valid_i  = 1'b0;
      out_ready_i = 1'b0;
      rst_n       = 1'b0;
      lfsr_q      = 16'd93;
      for (int f = 0; f < N_FRAMES; f++) begin
         build_frame();
      end
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      while (in_q.size() > 0) begin
         send_beat(in_q.pop_front());
      end
      while (frames_done < N_FRAMES) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      if (llcopy_unit_i.sva_i.err_cnt == 0 && exp_q.size() == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("%0d assertion errors, %0d beats still expected",
                  llcopy_unit_i.sva_i.err_cnt, exp_q.size());
         $display("Simulation FAILED");
         $fatal(1, "run ended with errors");
      end
   end

   // sink stalls about a quarter of the time
   initial begin
      @(posedge rst_n);
      forever begin
         @(posedge clk);
         #1 out_ready_i = (take_bits(2) != 32'd0);
      end
   end

   always @(negedge clk) begin
      llcopy_pkg::ll_beat_t exp_beat;
      string                name;
      if (rst_n && out_valid_o && out_ready_i) begin
         if (exp_q.size() == 0) begin
            $display("output beat arrived with no frame pending");
            $display("Simulation FAILED");
            $fatal(1, "unexpected output beat");
         end else begin
            exp_beat = exp_q.pop_front();
            name     = $sformatf("frame %0d beat %0d", frames_done, beat_no);
            check_word(name, exp_beat.data, out_beat_o.data);
            check_beat(name, exp_beat, out_beat_o);
            beat_no = beat_no + 1;
            if (out_beat_o.eof) begin
               frames_done = frames_done + 1;
               beat_no     = 0;
            end
         end
      end
   end

   initial begin
      repeat (MAX_CYCLES) @(posedge clk);
      $display("timeout: only %0d of %0d frames came out in %0d cycles",
               frames_done, N_FRAMES, MAX_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== llcopy.f ====
llcopy_pkg.sv
ingress_fsm.sv
desc_capture.sv
payload_fifo.sv
cpl_framer.sv
llcopy_unit.sv
llcopy_unit_sva.sv
tb_llcopy_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_llcopy_unit \
   -f llcopy.f -o sim_llcopy \
   && { out="$(./obj_dir/sim_llcopy)"; echo "$out"; grep -q "Simulation PASSED" <<< "$out"; } \
   && echo "run.sh: test run ok" \
   || { echo "run.sh: test run failed"; exit 1; }
